//--- build.f
+incdir+verif
hdl/mm_ram_pkg.sv
hdl/dp_ram.sv
hdl/sim_timer.sv
hdl/mem_bus_ctrl.sv
hdl/mm_ram_top.sv
verif/mm_ram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the RAM model testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module mm_ram_tb -o mm_ram_sim
out=$(./obj_dir/mm_ram_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- verif/mm_ram_tasks.svh
////////////////////
// bus helpers and directed tests for the RAM model testbench
////////////////////

task automatic value_error(input string tn, input logic [127:0] expected,
                           input logic [127:0] actual);
    $display("** Error %s: expected %0h, actual %0h", tn, expected, actual);
    error_count++;
endtask

task automatic failure_note(input string tn, input string what);
    $display("** Error %s: %s", tn, what);
    error_count++;
endtask

task automatic report_test(input string tn, input int errs_before);
    if (error_count == errs_before) begin
        $display("%s: ok", tn);
    end else begin
        failed_tests++;
        $display("%s: FAILED with %0d errors", tn, error_count - errs_before);
    end
endtask

// request on a falling edge and sample the response one cycle later
task automatic bus_cycle(input string tn, input logic we, input word_t addr,
                         input byte_en_t be, input word_t wdata, output word_t rdata);
    @(negedge clk_i);
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_be_i    = be;
    data_wdata_i = wdata;
    #1;
    if (data_gnt_o !== 1'b1) begin
        failure_note(tn, "data request not granted in its own cycle");
    end
    passed_seen   = tests_passed_o;
    failed_seen   = tests_failed_o;
    exit_seen     = exit_valid_o;
    exit_val_seen = exit_value_o;
    @(negedge clk_i);
    if (data_rvalid_o !== 1'b1) begin
        failure_note(tn, "no data rvalid in the cycle after the grant");
    end
    rdata      = data_rdata_o;
    data_req_i = 1'b0;
    data_we_i  = 1'b0;
endtask

task automatic data_write(input string tn, input word_t addr, input byte_en_t be,
                          input word_t wdata);
    word_t unused;
    bus_cycle(tn, 1'b1, addr, be, wdata, unused);
endtask

task automatic data_read(input string tn, input word_t addr, output word_t rdata);
    bus_cycle(tn, 1'b0, addr, 4'hf, '0, rdata);
endtask

task automatic instr_fetch(input string tn, input ram_addr_t addr, output instr_line_t line);
    @(negedge clk_i);
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    #1;
    if (instr_gnt_o !== 1'b1) begin
        failure_note(tn, "fetch not granted in its own cycle");
    end
    @(negedge clk_i);
    if (instr_rvalid_o !== 1'b1) begin
        failure_note(tn, "no fetch rvalid in the cycle after the request");
    end
    line        = instr_rdata_o;
    instr_req_i = 1'b0;
endtask

task automatic ram_word_rw();
    string    tn = "ram_word_rw";
    int       errs_before;
    word_t    addr;
    word_t    first;
    word_t    second;
    word_t    expected;
    word_t    rdata;
    byte_en_t be;
    errs_before = error_count;
    for (int n = 0; n < 16; n++) begin
        addr   = $urandom() & 32'h0000_fffc;
        first  = $urandom();
        second = $urandom();
        be     = byte_en_t'($urandom());
        data_write(tn, addr, 4'hf, first);
        data_write(tn, addr, be, second);
        // enabled lanes take the second word
        for (int b = 0; b < 4; b++) begin
            expected[8*b +: 8] = be[b] ? second[8*b +: 8] : first[8*b +: 8];
        end
        data_read(tn, addr, rdata);
        if (rdata !== expected) begin
            value_error(tn, expected, rdata);
        end
    end
    report_test(tn, errs_before);
endtask

task automatic instr_line_fetch();
    string       tn = "instr_line_fetch";
    int          errs_before;
    word_t       base;
    word_t       wdata;
    instr_line_t expected;
    instr_line_t line;
    errs_before = error_count;
    // second pass crosses the top of the RAM
    for (int t = 0; t < 2; t++) begin
        base = (t == 0) ? ($urandom() & 32'h0000_fffc) : 32'h0000_fff8;
        for (int i = 0; i < 4; i++) begin
            wdata = $urandom();
            data_write(tn, (base + 4 * i) & 32'h0000_ffff, 4'hf, wdata);
            expected[32*i +: 32] = wdata;
        end
        instr_fetch(tn, ram_addr_t'(base) | ram_addr_t'($urandom_range(3, 0)), line);
        if (line !== expected) begin
            value_error(tn, expected, line);
        end
    end
    report_test(tn, errs_before);
endtask

task automatic status_strobes();
    string tn = "status_strobes";
    int    errs_before;
    word_t other;
    errs_before = error_count;
    // top bit set keeps it clear of both magic values
    other = $urandom() | 32'h8000_0000;
    data_write(tn, TEST_STATUS_ADDR, 4'hf, TEST_PASS_VALUE);
    if ({passed_seen, failed_seen} !== 2'b10) begin
        value_error(tn, 2'b10, {passed_seen, failed_seen});
    end
    data_write(tn, TEST_STATUS_ADDR, 4'hf, TEST_FAIL_VALUE);
    if ({passed_seen, failed_seen} !== 2'b01) begin
        value_error(tn, 2'b01, {passed_seen, failed_seen});
    end
    data_write(tn, TEST_STATUS_ADDR, 4'hf, other);
    if ({passed_seen, failed_seen} !== 2'b00) begin
        value_error(tn, 2'b00, {passed_seen, failed_seen});
    end
    report_test(tn, errs_before);
endtask

task automatic exit_strobe();
    string tn = "exit_strobe";
    int    errs_before;
    word_t value;
    errs_before = error_count;
    value = $urandom();
    data_write(tn, EXIT_ADDR, 4'hf, value);
    if (exit_seen !== 1'b1) begin
        value_error(tn, 1'b1, exit_seen);
    end
    if (exit_val_seen !== value) begin
        value_error(tn, value, exit_val_seen);
    end
    // let the dropped request settle before looking at the strobe
    #1;
    if (exit_valid_o !== 1'b0 || exit_value_o !== '0) begin
        failure_note(tn, "exit outputs not zero once the write is over");
    end
    data_write(tn, TEST_STATUS_ADDR, 4'hf, value);
    if (exit_seen !== 1'b0 || exit_val_seen !== '0) begin
        failure_note(tn, "exit outputs raised by a write to another address");
    end
    report_test(tn, errs_before);
endtask

task automatic timer_countdown();
    string tn = "timer_countdown";
    int    errs_before;
    int    n_load;
    int    edges;
    logic  fired;
    errs_before = error_count;
    n_load = $urandom_range(20, 2);
    data_write(tn, TIMER_MASK_ADDR, 4'hf, word_t'(1) << TIMER_IRQ_ID);
    data_write(tn, TIMER_CNT_ADDR, 4'hf, word_t'(n_load));
    // we sit one falling edge past the load edge and count rising edges from here
    edges = 0;
    while (irq_o !== 1'b1 && edges < n_load + 8) begin
        @(negedge clk_i);
        edges++;
    end
    if (irq_o !== 1'b1) begin
        failure_note(tn, "timer irq never rose after the countdown");
    end else if (edges != n_load) begin
        value_error(tn, n_load, edges);
    end
    irq_ack_i = 1'b1;
    irq_id_i  = TIMER_IRQ_ID ^ 5'd1;
    @(negedge clk_i);
    if (irq_o !== 1'b1) begin
        failure_note(tn, "irq cleared by an ack for another interrupt id");
    end
    irq_id_i = TIMER_IRQ_ID;
    @(negedge clk_i);
    irq_ack_i = 1'b0;
    if (irq_o !== 1'b0) begin
        failure_note(tn, "irq not cleared by its own ack");
    end
    data_write(tn, TIMER_MASK_ADDR, 4'hf, ~(word_t'(1) << TIMER_IRQ_ID));
    data_write(tn, TIMER_CNT_ADDR, 4'hf, word_t'(n_load));
    fired = 1'b0;
    repeat (n_load + 4) begin
        @(negedge clk_i);
        if (irq_o !== 1'b0) begin
            fired = 1'b1;
        end
    end
    if (fired) begin
        failure_note(tn, "masked timer still raised its irq");
    end
    report_test(tn, errs_before);
endtask

task automatic unmapped_access();
    string tn = "unmapped_access";
    int    errs_before;
    word_t addr;
    word_t known;
    word_t rdata;
    errs_before = error_count;
    addr  = $urandom() & 32'h0000_fffc;
    known = $urandom();
    data_write(tn, addr, 4'hf, known);
    // same low bits as the RAM word so that aliasing would show up
    data_read(tn, 32'h4000_0000 | addr, rdata);
    if (rdata !== '0) begin
        value_error(tn, 0, rdata);
    end
    data_write(tn, 32'h4000_0000 | addr, 4'hf, ~known);
    data_read(tn, addr, rdata);
    if (rdata !== known) begin
        value_error(tn, known, rdata);
    end
    report_test(tn, errs_before);
endtask

//--- verif/mm_ram_tb.sv
////////////////////
// testbench for the memory-mapped RAM model
// clock, reset, watchdog and the directed test sequence
////////////////////

`timescale 1ns/1ns

module mm_ram_tb;
    import mm_ram_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 200;

    logic        clk_i;
    logic        rst_ni;
    logic        instr_req_i;
    ram_addr_t   instr_addr_i;
    instr_line_t instr_rdata_o;
    logic        instr_rvalid_o;
    logic        instr_gnt_o;
    logic        data_req_i;
    logic        data_we_i;
    word_t       data_addr_i;
    byte_en_t    data_be_i;
    word_t       data_wdata_i;
    word_t       data_rdata_o;
    logic        data_rvalid_o;
    logic        data_gnt_o;
    irq_id_t     irq_id_i;
    logic        irq_ack_i;
    logic        irq_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    word_t       exit_value_o;

    // strobes captured in the request cycle of the last data access
    logic        passed_seen;
    logic        failed_seen;
    logic        exit_seen;
    word_t       exit_val_seen;

    int          error_count;
    int          failed_tests;

    mm_ram_top i_dut (.*);

    `include "mm_ram_tasks.svh"

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        void'($urandom(3291));

        repeat (RESET_CYCLES) @(negedge clk_i);
        if (data_rvalid_o || instr_rvalid_o || irq_o || tests_passed_o
            || tests_failed_o || exit_valid_o) begin
            failure_note("reset", "outputs not idle during reset");
        end
        rst_ni = 1'b1;

        ram_word_rw();
        instr_line_fetch();
        status_strobes();
        exit_strobe();
        timer_countdown();
        unmapped_access();

        $display("%0d tests: %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // generous budget per test plus the reset phase
    initial begin
        #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- hdl/mm_ram_top.sv
////////////////////
// memory-mapped RAM model for a core's instruction and data ports
// RAM, bus decode and countdown timer
////////////////////

`timescale 1ns/1ns

module mm_ram_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    instr_req_i,
    input  mm_ram_pkg::ram_addr_t   instr_addr_i,
    output mm_ram_pkg::instr_line_t instr_rdata_o,
    output logic                    instr_rvalid_o,
    output logic                    instr_gnt_o,

    input  logic                    data_req_i,
    input  logic                    data_we_i,
    input  mm_ram_pkg::word_t       data_addr_i,
    input  mm_ram_pkg::byte_en_t    data_be_i,
    input  mm_ram_pkg::word_t       data_wdata_i,
    output mm_ram_pkg::word_t       data_rdata_o,
    output logic                    data_rvalid_o,
    output logic                    data_gnt_o,

    input  mm_ram_pkg::irq_id_t     irq_id_i,
    input  logic                    irq_ack_i,
    output logic                    irq_o,

    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output mm_ram_pkg::word_t       exit_value_o
);
    import mm_ram_pkg::*;

    // decode to RAM
    logic      ram_req;
    logic      ram_we;
    ram_addr_t ram_addr;
    byte_en_t  ram_be;
    word_t     ram_wdata;
    word_t     ram_rdata;
    logic      ram_rvalid;

    // decode to timer
    word_t     timer_wdata;
    logic      timer_mask_we;
    logic      timer_cnt_we;

    // the RAM never stalls fetches
    assign instr_gnt_o = instr_req_i;

    mem_bus_ctrl i_mem_bus_ctrl (
        .clk_i           ( clk_i          ),
        .rst_ni          ( rst_ni         ),
        .data_req_i      ( data_req_i     ),
        .data_we_i       ( data_we_i      ),
        .data_addr_i     ( data_addr_i    ),
        .data_be_i       ( data_be_i      ),
        .data_wdata_i    ( data_wdata_i   ),
        .data_rdata_o    ( data_rdata_o   ),
        .data_rvalid_o   ( data_rvalid_o  ),
        .data_gnt_o      ( data_gnt_o     ),
        .ram_req_o       ( ram_req        ),
        .ram_we_o        ( ram_we         ),
        .ram_addr_o      ( ram_addr       ),
        .ram_be_o        ( ram_be         ),
        .ram_wdata_o     ( ram_wdata      ),
        .ram_rdata_i     ( ram_rdata      ),
        .ram_rvalid_i    ( ram_rvalid     ),
        .timer_wdata_o   ( timer_wdata    ),
        .timer_mask_we_o ( timer_mask_we  ),
        .timer_cnt_we_o  ( timer_cnt_we   ),
        .tests_passed_o  ( tests_passed_o ),
        .tests_failed_o  ( tests_failed_o ),
        .exit_valid_o    ( exit_valid_o   ),
        .exit_value_o    ( exit_value_o   )
    );

    dp_ram i_dp_ram (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .instr_req_i    ( instr_req_i    ),
        .instr_addr_i   ( instr_addr_i   ),
        .instr_rdata_o  ( instr_rdata_o  ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .req_i          ( ram_req        ),
        .we_i           ( ram_we         ),
        .addr_i         ( ram_addr       ),
        .be_i           ( ram_be         ),
        .wdata_i        ( ram_wdata      ),
        .rdata_o        ( ram_rdata      ),
        .rvalid_o       ( ram_rvalid     )
    );

    sim_timer i_sim_timer (
        .clk_i     ( clk_i         ),
        .rst_ni    ( rst_ni        ),
        .wdata_i   ( timer_wdata   ),
        .mask_we_i ( timer_mask_we ),
        .cnt_we_i  ( timer_cnt_we  ),
        .irq_ack_i ( irq_ack_i     ),
        .irq_id_i  ( irq_id_i      ),
        .irq_o     ( irq_o         )
    );

endmodule

//--- hdl/mem_bus_ctrl.sv
////////////////////
// data-port decode against the memory map
// grant, rvalid, read mux and status/exit strobes
////////////////////

`timescale 1ns/1ns

module mem_bus_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  data_req_i,
    input  logic                  data_we_i,
    input  mm_ram_pkg::word_t     data_addr_i,
    input  mm_ram_pkg::byte_en_t  data_be_i,
    input  mm_ram_pkg::word_t     data_wdata_i,
    output mm_ram_pkg::word_t     data_rdata_o,
    output logic                  data_rvalid_o,
    output logic                  data_gnt_o,

    output logic                  ram_req_o,
    output logic                  ram_we_o,
    output mm_ram_pkg::ram_addr_t ram_addr_o,
    output mm_ram_pkg::byte_en_t  ram_be_o,
    output mm_ram_pkg::word_t     ram_wdata_o,
    input  mm_ram_pkg::word_t     ram_rdata_i,
    input  logic                  ram_rvalid_i,

    output mm_ram_pkg::word_t     timer_wdata_o,
    output logic                  timer_mask_we_o,
    output logic                  timer_cnt_we_o,

    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  exit_valid_o,
    output mm_ram_pkg::word_t     exit_value_o
);
    import mm_ram_pkg::*;

    resp_state_e resp_state_d;
    resp_state_e resp_state_q;

    logic addr_in_ram;
    logic periph_wr;

    // everything below 2^RAM_ADDR_WIDTH belongs to the RAM
    assign addr_in_ram = (data_addr_i[31:RAM_ADDR_WIDTH] == '0);

    // a write that is not aimed at the RAM
    assign periph_wr = data_req_i && data_we_i && !addr_in_ram;

    // every region accepts at once
    assign data_gnt_o = data_req_i;

    assign ram_req_o   = data_req_i && addr_in_ram;
    assign ram_we_o    = data_we_i;
    assign ram_addr_o  = {data_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};
    assign ram_be_o    = data_be_i;
    assign ram_wdata_o = data_wdata_i;

    assign timer_wdata_o   = data_wdata_i;
    assign timer_mask_we_o = periph_wr && (data_addr_i == TIMER_MASK_ADDR);
    assign timer_cnt_we_o  = periph_wr && (data_addr_i == TIMER_CNT_ADDR);

    // test status only reacts to the two magic values
    always_comb begin
        tests_passed_o = 1'b0;
        tests_failed_o = 1'b0;
        if (periph_wr && (data_addr_i == TEST_STATUS_ADDR)) begin
            tests_passed_o = (data_wdata_i == TEST_PASS_VALUE);
            tests_failed_o = (data_wdata_i == TEST_FAIL_VALUE);
        end
    end

    assign exit_valid_o = periph_wr && (data_addr_i == EXIT_ADDR);
    assign exit_value_o = exit_valid_o ? data_wdata_i : '0;

    // response owed next cycle, unmapped accesses answer like peripherals
    always_comb begin
        resp_state_d = RESP_IDLE;
        if (data_req_i) begin
            if (addr_in_ram) begin
                resp_state_d = RESP_RAM_VALID;
            end else begin
                resp_state_d = RESP_PERIPH_VALID;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_state_q <= RESP_IDLE;
        end else begin
            resp_state_q <= resp_state_d;
        end
    end

    // peripherals and holes read as zero
    always_comb begin
        data_rvalid_o = 1'b0;
        data_rdata_o  = '0;
        case (resp_state_q)
            RESP_PERIPH_VALID: begin
                data_rvalid_o = 1'b1;
            end
            RESP_RAM_VALID: begin
                data_rvalid_o = ram_rvalid_i;
                data_rdata_o  = ram_rdata_i;
            end
            default: begin
                data_rvalid_o = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/sim_timer.sv
////////////////////
// countdown timer with masked interrupt
////////////////////

`timescale 1ns/1ns

module sim_timer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  mm_ram_pkg::word_t   wdata_i,
    input  logic                mask_we_i,
    input  logic                cnt_we_i,
    input  logic                irq_ack_i,
    input  mm_ram_pkg::irq_id_t irq_id_i,
    output logic                irq_o
);
    import mm_ram_pkg::*;

    word_t irq_mask_q;
    word_t cnt_q;
    logic  irq_q;

    assign irq_o = irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_mask_q <= '0;
            cnt_q      <= '0;
            irq_q      <= 1'b0;
        end else begin
            if (mask_we_i) begin
                irq_mask_q <= wdata_i;
            end else if (cnt_we_i) begin
                cnt_q <= wdata_i;
            end else begin
                // count down, firing on the 1 -> 0 step
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end
                if ((cnt_q == 32'd1) && irq_mask_q[TIMER_IRQ_ID]) begin
                    irq_q <= 1'b1;
                end
            end

            // ack for our own line wins over a new expiry
            if (irq_ack_i && (irq_id_i == TIMER_IRQ_ID)) begin
                irq_q <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/dp_ram.sv
////////////////////
// dual-port byte RAM
// wide fetch port and byte-enabled data port
////////////////////

`timescale 1ns/1ns

module dp_ram (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // port a, instruction fetch
    input  logic                    instr_req_i,
    input  mm_ram_pkg::ram_addr_t   instr_addr_i,
    output mm_ram_pkg::instr_line_t instr_rdata_o,
    output logic                    instr_rvalid_o,

    // port b, data access
    input  logic                    req_i,
    input  logic                    we_i,
    input  mm_ram_pkg::ram_addr_t   addr_i,
    input  mm_ram_pkg::byte_en_t    be_i,
    input  mm_ram_pkg::word_t       wdata_i,
    output mm_ram_pkg::word_t       rdata_o,
    output logic                    rvalid_o
);
    import mm_ram_pkg::*;

    logic [7:0] mem [2**RAM_ADDR_WIDTH];
    ram_addr_t  instr_base;

    // fetch lines start on a word boundary
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};

    // lowest byte lands in the least significant lane, wraps at the top
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[ram_addr_t'(instr_base + i)];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            for (int i = 0; i < $bits(byte_en_t); i++) begin
                if (we_i) begin
                    if (be_i[i]) begin
                        mem[ram_addr_t'(addr_i + i)] <= wdata_i[8*i +: 8];
                    end
                end else begin
                    rdata_o[8*i +: 8] <= mem[ram_addr_t'(addr_i + i)];
                end
            end
        end
    end

    // both ports answer one cycle after the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
            rvalid_o       <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            rvalid_o       <= req_i;
        end
    end

endmodule

//--- hdl/mm_ram_pkg.sv
////////////////////
// shared definitions for the memory-mapped RAM model
// widths, word types, memory map and response states
////////////////////

package mm_ram_pkg;

    // RAM geometry
    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int INSTR_LINE_BYTES  = INSTR_RDATA_WIDTH / 8;

    typedef logic [31:0]                   word_t;
    typedef logic [RAM_ADDR_WIDTH-1:0]     ram_addr_t;
    typedef logic [INSTR_RDATA_WIDTH-1:0]  instr_line_t;
    typedef logic [3:0]                    byte_en_t;
    typedef logic [4:0]                    irq_id_t;

    // pseudo peripheral addresses on the data port
    localparam word_t TEST_STATUS_ADDR = 32'h2000_0000;
    localparam word_t EXIT_ADDR        = 32'h2000_0004;
    localparam word_t TIMER_MASK_ADDR  = 32'h1500_0000;
    localparam word_t TIMER_CNT_ADDR   = 32'h1500_0004;

    // values written to the test-status register
    localparam word_t TEST_PASS_VALUE = 32'd123456789;
    localparam word_t TEST_FAIL_VALUE = 32'd1;

    // interrupt line owned by the countdown timer
    localparam irq_id_t TIMER_IRQ_ID = 5'd3;

    // which response the data port owes in the next cycle
    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_PERIPH_VALID,
        RESP_RAM_VALID
    } resp_state_e;

endpackage
